/* source/mem_align_pkg.sv */
// Shared sizes, access size code and bus structs for the data-memory aligner and its testbench
`default_nettype none

package mem_align_pkg;

    // Address and data geometry
    localparam int addr_width       = 12;  // Byte address
    localparam int data_width       = 32;
    localparam int bytes_per_word   = 4;
    localparam int word_index_width = 10;  // Also log2 of RAM depth
    localparam int offset_width     = addr_width - word_index_width;  // Byte within word

    // Code 3 is an illegal access size
    typedef enum logic [1:0] {
        size_byte = 2'd0,
        size_half = 2'd1,
        size_word = 2'd2
    } access_size_t;

    // CPU load/store request
    typedef struct packed {
        logic [addr_width-1:0] addr;
        logic [data_width-1:0] wdata;  // Right-justified store data
        access_size_t          size;
        logic                  write;  // 1 for store
    } mem_req_t;

    // Response one cycle later
    typedef struct packed {
        logic [data_width-1:0] rdata;  // Zero-extended load data
        logic                  error;
    } mem_resp_t;

    // Write command from aligner to RAM
    typedef struct packed {
        logic [word_index_width-1:0] index;
        logic [data_width-1:0]       wdata;  // Full merged word
        logic                        write;
    } ram_cmd_t;

endpackage

`default_nettype wire

/* source/load_store_aligner.sv */
// Byte-lane aligner with alignment check and forwarding that sits between the CPU and a word RAM
`default_nettype none
`timescale 1ns/1ps

module load_store_aligner (
    input  logic                                      clk,
    input  logic                                      reset,
    input  logic                                      req_valid,  // Single-cycle strobe
    input  mem_align_pkg::mem_req_t                   req,
    output logic                                      resp_valid,
    output mem_align_pkg::mem_resp_t                  resp,
    output logic                                      ram_rd_en,
    output logic [mem_align_pkg::word_index_width-1:0] ram_rd_index,
    output mem_align_pkg::ram_cmd_t                   ram_cmd,
    input  logic [mem_align_pkg::data_width-1:0]      ram_rdata
);

    // Request cycle decode
    logic [mem_align_pkg::bytes_per_word-1:0] req_byte_en;  // Byte enables at offset 0
    logic [mem_align_pkg::offset_width-1:0]   req_offset;
    logic [mem_align_pkg::offset_width-1:0]   size_mask;    // Offset bits that must be zero
    logic                                     size_illegal;
    logic                                     req_error;

    // Response stage
    logic                                         s1_valid;
    logic                                         s1_write;
    logic                                         s1_error;
    logic [mem_align_pkg::word_index_width-1:0]   s1_index;
    logic [mem_align_pkg::offset_width-1:0]       s1_offset;
    logic [mem_align_pkg::bytes_per_word-1:0]     s1_byte_en;
    logic [mem_align_pkg::data_width-1:0]         s1_wdata;

    // Last written word for a read that raced the write
    logic                                         fwd_valid;
    logic [mem_align_pkg::word_index_width-1:0]   fwd_index;
    logic [mem_align_pkg::data_width-1:0]         fwd_word;

    // Response datapath
    logic                                         fwd_hit;
    logic [mem_align_pkg::offset_width+2:0]       shift_bits;  // Offset in bits
    logic [mem_align_pkg::data_width-1:0]         src_word;
    logic [mem_align_pkg::data_width-1:0]         lane_mask;
    logic [mem_align_pkg::data_width-1:0]         load_word;
    logic [mem_align_pkg::data_width-1:0]         shifted_mask;
    logic [mem_align_pkg::data_width-1:0]         shifted_wdata;
    logic [mem_align_pkg::data_width-1:0]         merged_word;
    logic                                         store_commit;

    // Size decode and alignment check
    always_comb
    begin
        req_offset   = req.addr[mem_align_pkg::offset_width-1:0];
        size_illegal = 1'b0;
        case (req.size)
            mem_align_pkg::size_byte:
            begin
                req_byte_en = 4'b0001;
                size_mask   = 2'b00;  // Any offset
            end
            mem_align_pkg::size_half:
            begin
                req_byte_en = 4'b0011;
                size_mask   = 2'b01;
            end
            mem_align_pkg::size_word:
            begin
                req_byte_en = 4'b1111;
                size_mask   = 2'b11;  // Word aligned only
            end
            default:
            begin
                // Code 3 enables no lanes
                req_byte_en  = 4'b0000;
                size_mask    = 2'b00;
                size_illegal = 1'b1;
            end
        endcase
        // Illegal size checked before misalignment
        req_error = size_illegal | (|(req_offset & size_mask));
    end

    // Read issued straight from the request
    assign ram_rd_en    = req_valid;
    assign ram_rd_index = req.addr[mem_align_pkg::addr_width-1:mem_align_pkg::offset_width];

    // Response stage control
    always_ff @(posedge clk)
    begin
        if (!reset)
        begin
            s1_valid <= 1'b0;
        end
        else
        begin
            s1_valid <= req_valid;  // Fixed one-cycle latency
        end
    end

    // Response stage payload captured on the strobe
    always_ff @(posedge clk)
    begin
        if (req_valid)
        begin
            s1_write   <= req.write;
            s1_error   <= req_error;
            s1_index   <= ram_rd_index;
            s1_offset  <= req_offset;
            s1_byte_en <= req_byte_en;
            s1_wdata   <= req.wdata;
        end
    end

    // Lane shifting and merge
    always_comb
    begin
        fwd_hit    = fwd_valid && (fwd_index == s1_index);
        src_word   = fwd_hit ? fwd_word : ram_rdata;  // RAM read saw the old word
        shift_bits = {s1_offset, 3'b000};
        for (int i = 0; i < mem_align_pkg::bytes_per_word; i++)
        begin
            lane_mask[8*i +: 8] = {8{s1_byte_en[i]}};
        end
        load_word     = (src_word >> shift_bits) & lane_mask;  // Down to bit 0 and zero-extended
        shifted_mask  = lane_mask << shift_bits;
        shifted_wdata = (s1_wdata & lane_mask) << shift_bits;
        merged_word   = (src_word & ~shifted_mask) | shifted_wdata;
        store_commit  = s1_valid && s1_write && !s1_error;  // Erroneous store writes nothing
    end

    assign resp_valid = s1_valid;
    assign resp.rdata = (s1_write || s1_error) ? '0 : load_word;  // Stores and errors return 0
    assign resp.error = s1_error;

    // Write back at end of response cycle
    assign ram_cmd.index = s1_index;
    assign ram_cmd.wdata = merged_word;
    assign ram_cmd.write = store_commit;

    // Forwarding flag covers only the edge of the write
    always_ff @(posedge clk)
    begin
        if (!reset)
        begin
            fwd_valid <= 1'b0;
        end
        else
        begin
            fwd_valid <= store_commit;
        end
    end

    always_ff @(posedge clk)
    begin
        if (store_commit)
        begin
            fwd_index <= s1_index;
            fwd_word  <= merged_word;  // Same word the RAM gets
        end
    end

endmodule

`default_nettype wire

/* source/word_ram.sv */
// Word-wide RAM with one write port and one registered read port behind the load/store aligner
`default_nettype none
`timescale 1ns/1ps

module word_ram (
    input  logic                                       clk,
    input  logic                                       rd_en,
    input  logic [mem_align_pkg::word_index_width-1:0] rd_index,
    input  mem_align_pkg::ram_cmd_t                    cmd,       // Write index, data, enable
    output logic [mem_align_pkg::data_width-1:0]       rdata
);

    // Storage contents undefined until written
    logic [mem_align_pkg::data_width-1:0] mem [0:(1 << mem_align_pkg::word_index_width)-1];

    // Write on the edge where write is high
    always_ff @(posedge clk)
    begin
        if (cmd.write)
        begin
            mem[cmd.index] <= cmd.wdata;
        end
    end

    // Synchronous read
    // A same-edge write to the same word is forwarded by the aligner
    always_ff @(posedge clk)
    begin
        if (rd_en)
        begin
            rdata <= mem[rd_index];
        end
    end

endmodule

`default_nettype wire

/* source/mem_align_top.sv */
// Data-memory port top where the CPU-side aligner feeds a word RAM with one-cycle latency
`default_nettype none
`timescale 1ns/1ps

module mem_align_top (
    input  logic                     clk,
    input  logic                     reset,
    input  logic                     req_valid,   // One strobe per access
    input  mem_align_pkg::mem_req_t  req,
    output logic                     resp_valid,  // Exactly one cycle after req_valid
    output mem_align_pkg::mem_resp_t resp
);

    // Aligner to RAM
    logic                                       ram_rd_en;
    logic [mem_align_pkg::word_index_width-1:0] ram_rd_index;
    mem_align_pkg::ram_cmd_t                    ram_cmd;
    logic [mem_align_pkg::data_width-1:0]       ram_rdata;

    // Size check, lane shift, merge
    load_store_aligner aligner0 (
        .clk          (clk),
        .reset        (reset),
        .req_valid    (req_valid),
        .req          (req),
        .resp_valid   (resp_valid),
        .resp         (resp),
        .ram_rd_en    (ram_rd_en),
        .ram_rd_index (ram_rd_index),
        .ram_cmd      (ram_cmd),
        .ram_rdata    (ram_rdata)
    );

    // Backing store
    word_ram ram0 (
        .clk      (clk),
        .rd_en    (ram_rd_en),
        .rd_index (ram_rd_index),
        .cmd      (ram_cmd),
        .rdata    (ram_rdata)
    );

endmodule

`default_nettype wire

/* tb/mem_align_checker.sv */
// Concurrent assertions on aligner strobe timing and RAM writes for binding into load_store_aligner
`default_nettype none
`timescale 1ns/1ps

module mem_align_checker (
    input logic                     clk,
    input logic                     reset,
    input logic                     req_valid,
    input logic                     resp_valid,
    input mem_align_pkg::mem_resp_t resp,
    input mem_align_pkg::ram_cmd_t  ram_cmd
);

    // Fixed one-cycle latency with no gaps or extra strobes
    resp_latency: assert property (@(posedge clk) disable iff (!reset)
        resp_valid == $past(req_valid))
        else $error("resp_valid is not req_valid delayed by one cycle");

    // Erroneous store never reaches the RAM
    no_write_on_error: assert property (@(posedge clk) disable iff (!reset)
        !(ram_cmd.write && resp.error))
        else $error("ram_cmd.write high together with resp.error");

    // Quiet while reset is held from the second reset edge on
    quiet_in_reset: assert property (@(posedge clk)
        (!reset && $past(!reset)) |-> !resp_valid)
        else $error("resp_valid high while in reset");

endmodule

`default_nettype wire

/* tb/mem_align_tb.sv */
// Testbench for the data-memory aligner that replays the cases file with random gaps
`default_nettype none
`timescale 1ns/1ps

module mem_align_tb;

    localparam string cases_path   = "tb/mem_align_cases.txt";
    localparam int    reset_cycles = 8;

    logic                     clk;
    logic                     reset;
    logic                     req_valid;
    mem_align_pkg::mem_req_t  req;
    logic                     resp_valid;
    mem_align_pkg::mem_resp_t resp;

    // Case table with one entry per file line
    logic [3:0]  case_op    [$];  // Bit 0 store, bit 1 no gap before
    logic [1:0]  case_size  [$];
    logic [11:0] case_addr  [$];
    logic [31:0] case_wdata [$];
    logic [31:0] case_rdata [$];  // Expected rdata
    logic        case_error [$];  // Expected error flag

    int   pending [$];        // Case numbers awaiting response
    logic resp_due = 1'b0;    // Strobe seen at last falling edge
    int   cycle_count = 0;
    int   cycle_limit = 0;    // Zero until cases are loaded
    int   pass_count = 0;
    int   fail_count = 0;
    int   error_count = 0;    // Timing and protocol problems

    mem_align_top dut0 (
        .clk        (clk),
        .reset      (reset),
        .req_valid  (req_valid),
        .req        (req),
        .resp_valid (resp_valid),
        .resp       (resp)
    );

    bind load_store_aligner mem_align_checker checker0 (
        .clk        (clk),
        .reset      (reset),
        .req_valid  (req_valid),
        .resp_valid (resp_valid),
        .resp       (resp),
        .ram_cmd    (ram_cmd)
    );

    // 8 ns clock
    always
    begin
        clk = 1'b0;
        #4;
        clk = 1'b1;
        #4;
    end

    // Load the table and skip comment lines
    function automatic bit read_cases();
        int          fd;
        int          n;
        string       line;
        logic [3:0]  op;
        logic [1:0]  size;
        logic [11:0] addr;
        logic [31:0] wdata;
        logic [31:0] rdata;
        logic        err;
        fd = $fopen(cases_path, "r");
        if (fd == 0)
        begin
            $display("Cannot open cases file %s", cases_path);
            return 1'b0;
        end
        while (!$feof(fd))
        begin
            if ($fgets(line, fd) == 0)
            begin
                break;
            end
            if (line.len() == 0 || line[0] == "#")
            begin
                continue;
            end
            n = $sscanf(line, "%h %h %h %h %h %h", op, size, addr, wdata, rdata, err);
            if (n == 6)
            begin
                case_op.push_back(op);
                case_size.push_back(size);
                case_addr.push_back(addr);
                case_wdata.push_back(wdata);
                case_rdata.push_back(rdata);
                case_error.push_back(err);
            end
        end
        $fclose(fd);
        return case_op.size() > 0;
    endfunction

    // One request strobe on the next rising edge
    task automatic send_case(input int idx);
        @(posedge clk);
        req_valid  <= 1'b1;
        req.addr   <= case_addr[idx];
        req.wdata  <= case_wdata[idx];
        req.size   <= mem_align_pkg::access_size_t'(case_size[idx]);  // Code 3 passes through
        req.write  <= case_op[idx][0];
        pending.push_back(idx);
    endtask

    task automatic idle_cycles(input int n);
        repeat (n)
        begin
            @(posedge clk);
            req_valid <= 1'b0;
        end
    endtask

    // Compare one response with the table entry at the head of the queue
    task automatic check_response();
        int idx;
        bit case_ok;
        if (pending.size() == 0)
        begin
            $display("Response seen with no request outstanding");
            error_count++;
        end
        else
        begin
            idx     = pending.pop_front();
            case_ok = 1'b1;
            assert (resp.rdata === case_rdata[idx])
            else
            begin
                $display("FAIL resp.rdata case %0d: got %h, expected %h",
                         idx, resp.rdata, case_rdata[idx]);
                case_ok = 1'b0;
            end
            assert (resp.error === case_error[idx])
            else
            begin
                $display("FAIL resp.error case %0d: got %h, expected %h",
                         idx, resp.error, case_error[idx]);
                case_ok = 1'b0;
            end
            if (case_ok)
            begin
                pass_count++;
            end
            else
            begin
                fail_count++;
            end
            $display("Case %0d %s size %0d addr %h: %s", idx,
                     case_op[idx][0] ? "store" : "load", case_size[idx], case_addr[idx],
                     case_ok ? "ok" : "mismatch");
        end
    endtask

    // Outputs sampled mid-cycle away from the driving edge
    always @(negedge clk)
    begin
        if (reset)
        begin
            assert (resp_valid === resp_due)
            else
            begin
                $display("Response strobe was %0b one cycle after request strobe %0b",
                         resp_valid, resp_due);
                error_count++;
            end
            if (resp_valid === 1'b1)
            begin
                check_response();
            end
        end
        resp_due = reset && req_valid;  // Owed at next falling edge
    end

    // Watchdog
    always @(posedge clk)
    begin
        cycle_count <= cycle_count + 1;
        if (cycle_limit > 0 && cycle_count >= cycle_limit)
        begin
            $display("Timeout after %0d cycles, %0d responses outstanding",
                     cycle_count, pending.size());
            $display("Simulation finished: FAIL");
            $finish;
        end
    end

    initial
    begin
        int gap;
        void'($urandom(63));
        reset      = 1'b0;
        req_valid  = 1'b0;
        req        = '0;
        if (!read_cases())
        begin
            $display("No cases loaded from %s", cases_path);
            $display("Simulation finished: FAIL");
            $finish;
        end
        else
        begin
            cycle_limit = case_op.size() * 4 + 100;
            repeat (reset_cycles) @(posedge clk);
            reset <= 1'b1;
            for (int i = 0; i < case_op.size(); i++)
            begin
                if (!case_op[i][1])
                begin
                    gap = $urandom % 3;  // 0 to 2 idle cycles
                    idle_cycles(gap);
                end
                send_case(i);
            end
            idle_cycles(1);
            while (pending.size() != 0)
            begin
                @(posedge clk);
            end
            repeat (2) @(posedge clk);
            $display("Cases %0d, matched %0d, mismatched %0d, other errors %0d",
                     case_op.size(), pass_count, fail_count, error_count);
            if (fail_count == 0 && error_count == 0 && pass_count == case_op.size())
            begin
                $display("Simulation finished: PASS");
            end
            else
            begin
                $display("Simulation finished: FAIL");
            end
            $finish;
        end
    end

endmodule

`default_nettype wire

/* mem_align_top.f */
source/mem_align_pkg.sv
source/load_store_aligner.sv
source/word_ram.sv
source/mem_align_top.sv
tb/mem_align_checker.sv
tb/mem_align_tb.sv

/* Makefile */
# Verilator build and run of the data-memory aligner testbench

VERILATOR ?= verilator
TOP       ?= mem_align_tb
FILELIST  ?= mem_align_top.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert
FAIL_MSG  := Simulation finished: FAIL
PASS_MSG  := Simulation finished: PASS

SOURCES := $(shell grep -v '^+' $(FILELIST))
SIM_BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench, check $(LOG)"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "  help   show this list"
	@echo "Variables: VERILATOR TOP FILELIST BUILD_DIR LOG VFLAGS"

$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

test: $(SIM_BIN)
	./$(SIM_BIN) 2>&1 | tee $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then \
		echo "Test failed, see $(LOG)"; exit 1; \
	elif ! grep -q "$(PASS_MSG)" $(LOG); then \
		echo "Run ended without a verdict, see $(LOG)"; exit 1; \
	else \
		echo "Test passed"; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* tb/mem_align_cases.txt */
# op size addr wdata exp_rdata exp_error, all hex
# op bit 0 = store, op bit 1 = sent right after the previous case; size 0 byte 1 half 2 word
1 2 000 11223344 00000000 0
1 2 004 a5a5a5a5 00000000 0
1 2 008 deadbeef 00000000 0
1 2 00c 00000000 00000000 0
1 2 ffc 89abcdef 00000000 0
1 2 800 cafef00d 00000000 0
0 2 000 00000000 11223344 0
0 2 004 00000000 a5a5a5a5 0
0 2 ffc 00000000 89abcdef 0
0 2 800 00000000 cafef00d 0
0 0 008 00000000 000000ef 0
0 0 009 00000000 000000be 0
0 0 00a 00000000 000000ad 0
0 0 00b 00000000 000000de 0
0 1 008 00000000 0000beef 0
0 1 00a 00000000 0000dead 0
0 0 003 00000000 00000011 0
0 1 ffe 00000000 000089ab 0
1 0 00d 123456ff 00000000 0
1 1 00e 9999beef 00000000 0
0 2 00c 00000000 beefff00 0
1 0 00c 00000077 00000000 0
0 2 00c 00000000 beefff77 0
1 1 000 0000abcd 00000000 0
0 2 000 00000000 1122abcd 0
0 1 001 00000000 00000000 1
0 2 002 00000000 00000000 1
0 2 006 00000000 00000000 1
0 3 004 00000000 00000000 1
1 2 005 ffffffff 00000000 1
1 1 003 ffffffff 00000000 1
1 3 004 ffffffff 00000000 1
0 2 004 00000000 a5a5a5a5 0
0 1 00b 00000000 00000000 1
1 3 000 ffffffff 00000000 1
0 2 000 00000000 1122abcd 0
1 2 010 01020304 00000000 0
2 2 010 00000000 01020304 0
1 0 011 000000aa 00000000 0
2 2 010 00000000 0102aa04 0
1 1 012 0000bbcc 00000000 0
3 0 013 000000dd 00000000 0
2 0 013 00000000 000000dd 0
2 2 010 00000000 ddccaa04 0
3 2 014 0a0b0c0d 00000000 0
3 2 018 1a1b1c1d 00000000 0
2 2 014 00000000 0a0b0c0d 0
2 1 01a 00000000 00001a1b 0
3 2 016 ffffffff 00000000 1
2 2 014 00000000 0a0b0c0d 0
3 0 018 00000055 00000000 0
2 2 000 00000000 1122abcd 0
2 2 018 00000000 1a1b1c55 0
0 2 00c 00000000 beefff77 0
0 0 ffc 00000000 000000ef 0
